//--- hdl/vgpr_bank.sv
`timescale 1ns/1ps

module vgpr_bank
  import vgpr_pkg::*;
#(
  parameter int NUM_LANES = NUM_LANES_DEF
)
(
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  quad_en_t                     wr_en_i,
  input  lane_mask_t                   wr_mask_i,
  input  vgpr_addr_t                   wr_addr_i,
  input  vgpr_word_t [NUM_LANES*4-1:0] wr_data_i,
  input  vgpr_addr_t                   dbg_addr_i,
  input  logic [1:0]                   dbg_lane_i,
  output vgpr_word_t                   dbg_data_o
);

  localparam int NUM_REGS = 2 ** $bits(vgpr_addr_t);
  localparam int QUADS    = $bits(quad_en_t);

  vgpr_word_t mem_q [NUM_REGS][NUM_LANES];
  vgpr_addr_t row   [QUADS];

  for (genvar k = 0; k < QUADS; k++)
  begin : g_row
    assign row[k] = wr_addr_i + vgpr_addr_t'(k);  // wraps modulo 64
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int r = 0; r < NUM_REGS; r++)
      begin
        for (int l = 0; l < NUM_LANES; l++)
          mem_q[r][l] <= '0;
      end
    end
    else
    begin
      // quad k of each lane lands in register addr+k
      for (int k = 0; k < QUADS; k++)
      begin
        for (int l = 0; l < NUM_LANES; l++)
        begin
          if (wr_en_i[k] && wr_mask_i[l])
            mem_q[row[k]][l] <= wr_data_i[l*QUADS + k];
        end
      end
    end
  end

  // debug port, one cycle behind its address
  always_ff @(posedge clk_i)
  begin
    dbg_data_o <= mem_q[dbg_addr_i][dbg_lane_i];
  end

endmodule

//--- hdl/vgpr_csr.sv
`timescale 1ns/1ps

module vgpr_csr
  import vgpr_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  axi_addr_t   s_axi_awaddr_i,
  input  logic        s_axi_awvalid_i,
  output logic        s_axi_awready_o,
  input  logic [31:0] s_axi_wdata_i,
  input  logic [3:0]  s_axi_wstrb_i,
  input  logic        s_axi_wvalid_i,
  output logic        s_axi_wready_o,
  output axi_resp_t   s_axi_bresp_o,
  output logic        s_axi_bvalid_o,
  input  logic        s_axi_bready_i,
  input  axi_addr_t   s_axi_araddr_i,
  input  logic        s_axi_arvalid_i,
  output logic        s_axi_arready_o,
  output logic [31:0] s_axi_rdata_o,
  output axi_resp_t   s_axi_rresp_o,
  output logic        s_axi_rvalid_o,
  input  logic        s_axi_rready_i,
  input  logic        wr_commit_i,
  output port_sel_t   port_en_o,
  output vgpr_addr_t  dbg_addr_o,
  output logic [1:0]  dbg_lane_o,
  input  vgpr_word_t  dbg_data_i
);

  typedef enum logic {WR_IDLE, WR_RESP} wr_state_e;
  typedef enum logic [1:0] {RD_IDLE, RD_WAIT, RD_RESP} rd_state_e;

  wr_state_e   wr_state_q;
  rd_state_e   rd_state_q;
  logic        aw_accept_q;  // drives awready and wready together
  logic        ar_accept_q;
  logic        wr_fire;
  logic        rd_fire;
  axi_resp_e   wr_resp;
  axi_resp_e   rd_resp;
  logic [31:0] rd_word;
  axi_addr_t   rd_addr_q;
  axi_resp_e   bresp_q;
  axi_resp_e   rresp_q;
  logic [31:0] rdata_q;
  port_sel_t   port_en_q;
  logic [31:0] wr_count_q;
  vgpr_addr_t  dbg_addr_q;
  logic [1:0]  dbg_lane_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~ write channel ~~~~~~~~~~~~~~~~~~~~~~~~~

  assign wr_fire = aw_accept_q && s_axi_awvalid_i && s_axi_wvalid_i;

  // DBG_DATA is read only, so only three offsets take a write
  assign wr_resp = (s_axi_awaddr_i == REG_PORT_EN  ||
                    s_axi_awaddr_i == REG_WR_COUNT ||
                    s_axi_awaddr_i == REG_DBG_ADDR) ? RESP_OKAY : RESP_SLVERR;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_state_q  <= WR_IDLE;
      aw_accept_q <= 1'b0;
    end
    else
    begin
      aw_accept_q <= (wr_state_q == WR_IDLE) && s_axi_awvalid_i && s_axi_wvalid_i &&
                     !aw_accept_q;
      case (wr_state_q)
        WR_IDLE: if (wr_fire) wr_state_q <= WR_RESP;
        WR_RESP: if (s_axi_bready_i) wr_state_q <= WR_IDLE;
        default: wr_state_q <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      port_en_q  <= '1;   // all ports enabled out of reset
      wr_count_q <= '0;
      dbg_addr_q <= '0;
      dbg_lane_q <= '0;
    end
    else
    begin
      if (wr_commit_i)
        wr_count_q <= wr_count_q + 32'd1;
      if (wr_fire)
      begin
        case (s_axi_awaddr_i)
          REG_PORT_EN:  if (s_axi_wstrb_i[0]) port_en_q <= s_axi_wdata_i[3:0];
          REG_WR_COUNT: wr_count_q <= '0;  // the data is ignored, clear wins over a commit
          REG_DBG_ADDR:
          begin
            if (s_axi_wstrb_i[0])
              dbg_addr_q <= s_axi_wdata_i[5:0];
            if (s_axi_wstrb_i[1])
              dbg_lane_q <= s_axi_wdata_i[9:8];
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_fire)
      bresp_q <= wr_resp;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~ read channel ~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign rd_fire = ar_accept_q && s_axi_arvalid_i;

  always_comb
  begin
    rd_word = '0;
    rd_resp = RESP_OKAY;
    case (rd_addr_q)
      REG_PORT_EN:  rd_word = {28'd0, port_en_q};
      REG_WR_COUNT: rd_word = wr_count_q;
      REG_DBG_ADDR: rd_word = {22'd0, dbg_lane_q, 2'd0, dbg_addr_q};
      REG_DBG_DATA: rd_word = dbg_data_i;
      default:      rd_resp = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rd_state_q  <= RD_IDLE;
      ar_accept_q <= 1'b0;
    end
    else
    begin
      ar_accept_q <= (rd_state_q == RD_IDLE) && s_axi_arvalid_i && !ar_accept_q;
      case (rd_state_q)
        RD_IDLE: if (rd_fire) rd_state_q <= RD_WAIT;
        RD_WAIT: rd_state_q <= RD_RESP;  // bank word settles during this cycle
        RD_RESP: if (s_axi_rready_i) rd_state_q <= RD_IDLE;
        default: rd_state_q <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rd_fire)
      rd_addr_q <= s_axi_araddr_i;
    if (rd_state_q == RD_WAIT)
    begin
      rdata_q <= rd_word;
      rresp_q <= rd_resp;
    end
  end

  assign s_axi_awready_o = aw_accept_q;
  assign s_axi_wready_o  = aw_accept_q;
  assign s_axi_bvalid_o  = (wr_state_q == WR_RESP);
  assign s_axi_bresp_o   = bresp_q;
  assign s_axi_arready_o = ar_accept_q;
  assign s_axi_rvalid_o  = (rd_state_q == RD_RESP);
  assign s_axi_rdata_o   = rdata_q;
  assign s_axi_rresp_o   = rresp_q;

  assign port_en_o  = port_en_q;
  assign dbg_addr_o = dbg_addr_q;
  assign dbg_lane_o = dbg_lane_q;

endmodule

//--- hdl/vgpr_pkg.sv
package vgpr_pkg;

  localparam int NUM_LANES_DEF = 4;
  localparam int NUM_PORTS_DEF = 4;

  typedef logic [5:0]  vgpr_addr_t;
  typedef logic [31:0] vgpr_word_t;
  typedef logic [3:0]  lane_mask_t;
  typedef logic [3:0]  quad_en_t;   // bit k writes register addr+k
  typedef logic [3:0]  port_sel_t;
  typedef logic [3:0]  axi_addr_t;
  typedef logic [1:0]  axi_resp_t;

  typedef enum axi_resp_t
  {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // register block byte offsets
  localparam axi_addr_t REG_PORT_EN  = 4'h0;
  localparam axi_addr_t REG_WR_COUNT = 4'h4;
  localparam axi_addr_t REG_DBG_ADDR = 4'h8;
  localparam axi_addr_t REG_DBG_DATA = 4'hC;

endpackage

//--- hdl/vgpr_wr_arbiter.sv
`timescale 1ns/1ps

module vgpr_wr_arbiter
  import vgpr_pkg::*;
#(
  parameter int NUM_PORTS = NUM_PORTS_DEF
)
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  port_sel_t req_i,
  input  port_sel_t port_en_i,
  output port_sel_t sel_o
);

  localparam int PTR_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

  typedef logic [PTR_W-1:0] ptr_t;

  port_sel_t req_act;
  ptr_t      ptr_q;
  ptr_t      gnt_idx;

  assign req_act = req_i & port_en_i; // a disabled port just waits here

  // first active request at or after the pointer wins
  always_comb
  begin
    int   cand;
    logic found;
    cand    = 0;
    found   = 1'b0;
    sel_o   = '0;
    gnt_idx = ptr_q;
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      cand = int'(ptr_q) + i;
      if (cand >= NUM_PORTS)
        cand = cand - NUM_PORTS;
      if (!found && req_act[cand])
      begin
        sel_o[cand] = 1'b1;
        gnt_idx     = ptr_t'(cand);
        found       = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      ptr_q <= '0;
    else if (|sel_o)
      ptr_q <= (gnt_idx == ptr_t'(NUM_PORTS - 1)) ? '0 : gnt_idx + ptr_t'(1);
  end

endmodule

//--- hdl/vgpr_wr_port_mux.sv
`timescale 1ns/1ps

module vgpr_wr_port_mux
  import vgpr_pkg::*;
#(
  parameter int NUM_LANES = NUM_LANES_DEF,
  parameter int NUM_PORTS = NUM_PORTS_DEF
)
(
  input  port_sel_t                    sel_i,
  input  quad_en_t                     port0_wr_en_i,
  input  lane_mask_t                   port0_wr_mask_i,
  input  vgpr_addr_t                   port0_wr_addr_i,
  input  vgpr_word_t [NUM_LANES-1:0]   port0_wr_data_i,
  input  quad_en_t                     port1_wr_en_i,
  input  lane_mask_t                   port1_wr_mask_i,
  input  vgpr_addr_t                   port1_wr_addr_i,
  input  vgpr_word_t [NUM_LANES-1:0]   port1_wr_data_i,
  input  quad_en_t                     port2_wr_en_i,
  input  lane_mask_t                   port2_wr_mask_i,
  input  vgpr_addr_t                   port2_wr_addr_i,
  input  vgpr_word_t [NUM_LANES-1:0]   port2_wr_data_i,
  input  quad_en_t                     port3_wr_en_i,
  input  lane_mask_t                   port3_wr_mask_i,
  input  vgpr_addr_t                   port3_wr_addr_i,
  input  vgpr_word_t [NUM_LANES*4-1:0] port3_wr_data_i,
  output quad_en_t                     muxed_wr_en_o,
  output lane_mask_t                   muxed_wr_mask_o,
  output vgpr_addr_t                   muxed_wr_addr_o,
  output vgpr_word_t [NUM_LANES*4-1:0] muxed_wr_data_o
);

  localparam int QUADS = $bits(quad_en_t);

  typedef vgpr_word_t [NUM_LANES-1:0]       narrow_data_t;
  typedef vgpr_word_t [NUM_LANES*QUADS-1:0] wide_data_t;

  // lane word goes to quad 0, the upper quads read as zero
  function automatic wide_data_t widen(input narrow_data_t narrow);
    wide_data_t wide;
    wide = '0;
    for (int l = 0; l < NUM_LANES; l++)
      wide[l*QUADS] = narrow[l];
    return wide;
  endfunction

  quad_en_t   en_arr   [NUM_PORTS];
  lane_mask_t mask_arr [NUM_PORTS];
  vgpr_addr_t addr_arr [NUM_PORTS];
  wide_data_t data_arr [NUM_PORTS];

  assign en_arr[0]   = port0_wr_en_i;
  assign en_arr[1]   = port1_wr_en_i;
  assign en_arr[2]   = port2_wr_en_i;
  assign en_arr[3]   = port3_wr_en_i;
  assign mask_arr[0] = port0_wr_mask_i;
  assign mask_arr[1] = port1_wr_mask_i;
  assign mask_arr[2] = port2_wr_mask_i;
  assign mask_arr[3] = port3_wr_mask_i;
  assign addr_arr[0] = port0_wr_addr_i;
  assign addr_arr[1] = port1_wr_addr_i;
  assign addr_arr[2] = port2_wr_addr_i;
  assign addr_arr[3] = port3_wr_addr_i;
  assign data_arr[0] = widen(port0_wr_data_i);
  assign data_arr[1] = widen(port1_wr_data_i);
  assign data_arr[2] = widen(port2_wr_data_i);
  assign data_arr[3] = port3_wr_data_i;    // load port is already wide

  // and-or select, an empty select leaves everything at zero
  always_comb
  begin
    muxed_wr_en_o   = '0;
    muxed_wr_mask_o = '0;
    muxed_wr_addr_o = '0;
    muxed_wr_data_o = '0;
    for (int k = 0; k < NUM_PORTS; k++)
    begin
      if (sel_i[k])
      begin
        muxed_wr_en_o   = muxed_wr_en_o | en_arr[k];
        muxed_wr_mask_o = muxed_wr_mask_o | mask_arr[k];
        muxed_wr_addr_o = muxed_wr_addr_o | addr_arr[k];
        muxed_wr_data_o = muxed_wr_data_o | data_arr[k];
      end
    end
  end

endmodule

//--- hdl/vgpr_wr_top.sv
`timescale 1ns/1ps

module vgpr_wr_top
  import vgpr_pkg::*;
#(
  parameter int NUM_LANES = NUM_LANES_DEF,
  parameter int NUM_PORTS = NUM_PORTS_DEF
)
(
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  quad_en_t                     port0_wr_en_i,
  input  lane_mask_t                   port0_wr_mask_i,
  input  vgpr_addr_t                   port0_wr_addr_i,
  input  vgpr_word_t [NUM_LANES-1:0]   port0_wr_data_i,
  output logic                         port0_wr_gnt_o,
  input  quad_en_t                     port1_wr_en_i,
  input  lane_mask_t                   port1_wr_mask_i,
  input  vgpr_addr_t                   port1_wr_addr_i,
  input  vgpr_word_t [NUM_LANES-1:0]   port1_wr_data_i,
  output logic                         port1_wr_gnt_o,
  input  quad_en_t                     port2_wr_en_i,
  input  lane_mask_t                   port2_wr_mask_i,
  input  vgpr_addr_t                   port2_wr_addr_i,
  input  vgpr_word_t [NUM_LANES-1:0]   port2_wr_data_i,
  output logic                         port2_wr_gnt_o,
  input  quad_en_t                     port3_wr_en_i,
  input  lane_mask_t                   port3_wr_mask_i,
  input  vgpr_addr_t                   port3_wr_addr_i,
  input  vgpr_word_t [NUM_LANES*4-1:0] port3_wr_data_i,
  output logic                         port3_wr_gnt_o,
  input  axi_addr_t                    s_axi_awaddr_i,
  input  logic                         s_axi_awvalid_i,
  output logic                         s_axi_awready_o,
  input  logic [31:0]                  s_axi_wdata_i,
  input  logic [3:0]                   s_axi_wstrb_i,
  input  logic                         s_axi_wvalid_i,
  output logic                         s_axi_wready_o,
  output axi_resp_t                    s_axi_bresp_o,
  output logic                         s_axi_bvalid_o,
  input  logic                         s_axi_bready_i,
  input  axi_addr_t                    s_axi_araddr_i,
  input  logic                         s_axi_arvalid_i,
  output logic                         s_axi_arready_o,
  output logic [31:0]                  s_axi_rdata_o,
  output axi_resp_t                    s_axi_rresp_o,
  output logic                         s_axi_rvalid_o,
  input  logic                         s_axi_rready_i
);

  port_sel_t                    req;
  port_sel_t                    port_en;
  port_sel_t                    sel;
  logic                         wr_commit;
  quad_en_t                     muxed_wr_en;
  lane_mask_t                   muxed_wr_mask;
  vgpr_addr_t                   muxed_wr_addr;
  vgpr_word_t [NUM_LANES*4-1:0] muxed_wr_data;
  vgpr_addr_t                   dbg_addr;
  logic [1:0]                   dbg_lane;
  vgpr_word_t                   dbg_data;

  // a port requests while its enable is nonzero
  assign req = {|port3_wr_en_i, |port2_wr_en_i, |port1_wr_en_i, |port0_wr_en_i};

  assign port0_wr_gnt_o = sel[0];
  assign port1_wr_gnt_o = sel[1];
  assign port2_wr_gnt_o = sel[2];
  assign port3_wr_gnt_o = sel[3];
  assign wr_commit      = |sel;  // one commit per granted beat

  vgpr_wr_arbiter #(.NUM_PORTS(NUM_PORTS)) u_arbiter
  (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (req),
    .port_en_i (port_en),
    .sel_o     (sel)
  );

  vgpr_wr_port_mux #(.NUM_LANES(NUM_LANES), .NUM_PORTS(NUM_PORTS)) u_port_mux
  (
    .sel_i           (sel),
    .muxed_wr_en_o   (muxed_wr_en),
    .muxed_wr_mask_o (muxed_wr_mask),
    .muxed_wr_addr_o (muxed_wr_addr),
    .muxed_wr_data_o (muxed_wr_data),
    .*
  );

  vgpr_bank #(.NUM_LANES(NUM_LANES)) u_bank
  (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wr_en_i    (muxed_wr_en),
    .wr_mask_i  (muxed_wr_mask),
    .wr_addr_i  (muxed_wr_addr),
    .wr_data_i  (muxed_wr_data),
    .dbg_addr_i (dbg_addr),
    .dbg_lane_i (dbg_lane),
    .dbg_data_o (dbg_data)
  );

  // AXI ports, clock and reset connect by name
  vgpr_csr u_csr
  (
    .wr_commit_i (wr_commit),
    .port_en_o   (port_en),
    .dbg_addr_o  (dbg_addr),
    .dbg_lane_o  (dbg_lane),
    .dbg_data_i  (dbg_data),
    .*
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the vector register file write path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f vgpr_wr.f --top-module tb_vgpr_wr_top -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_sim +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
#(
  parameter real PERIOD_NS    = 8.0,
  parameter int  RESET_CYCLES = 8
)
(
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  initial
  begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;  // release just after an edge
  end

endmodule

//--- testbench/tb_vgpr_wr_top.sv
`timescale 1ns/1ps

module tb_vgpr_wr_top
  import vgpr_pkg::*;
();

  localparam int NUM_LANES       = NUM_LANES_DEF;
  localparam int NUM_PORTS       = NUM_PORTS_DEF;
  localparam int QUADS           = 4;
  localparam int NUM_ENT         = 14;
  localparam int NUM_TESTS       = 6;
  localparam int STALL_ENT       = 12;
  localparam int CLK_NS          = 8;
  localparam int WATCHDOG_CYCLES = 200 * NUM_ENT + 2000;

  typedef struct {
    int          test;
    int          port;
    quad_en_t    en;
    lane_mask_t  mask;
    vgpr_addr_t  addr;
    int          start;
    logic [31:0] seed;
  } entry_t;

  // test, port, enable, mask, address, start cycle, data seed
  entry_t stim [NUM_ENT] = '{
    '{2, 0, 4'h1, 4'h5, 6'd10,  0, 32'h0000_1111},
    '{2, 1, 4'h1, 4'hA, 6'd10,  4, 32'h0000_2222},
    '{2, 0, 4'h1, 4'h3, 6'd11,  8, 32'h0000_3333},
    '{2, 1, 4'h1, 4'hF, 6'd20,  8, 32'h0000_4444},
    '{3, 3, 4'hF, 4'hF, 6'd30, 12, 32'h0000_5555},
    '{3, 3, 4'h5, 4'h6, 6'd40, 16, 32'h0000_6666},
    '{3, 3, 4'hF, 4'h9, 6'd62, 20, 32'h0000_7777},  // wraps to 0 and 1
    '{4, 0, 4'h1, 4'hF, 6'd50, 26, 32'h0000_8888},
    '{4, 1, 4'h1, 4'hF, 6'd51, 26, 32'h0000_9999},
    '{4, 2, 4'h1, 4'hF, 6'd52, 26, 32'h0000_AAAA},
    '{4, 3, 4'h3, 4'hF, 6'd53, 26, 32'h0000_BBBB},
    '{4, 1, 4'h1, 4'h6, 6'd55, 26, 32'h0000_CCCC},
    '{5, 2, 4'h1, 4'h7, 6'd5,  60, 32'h0000_DDDD},  // held while port 2 is disabled
    '{5, 0, 4'h1, 4'hF, 6'd6,  62, 32'h0000_EEEE}
  };

  logic        clk;
  logic        rst_n;
  quad_en_t    wr_en   [NUM_PORTS];
  lane_mask_t  wr_mask [NUM_PORTS];
  vgpr_addr_t  wr_addr [NUM_PORTS];
  vgpr_word_t [NUM_LANES-1:0]       narrow_data [NUM_PORTS-1];
  vgpr_word_t [NUM_LANES*QUADS-1:0] wide_data;
  wire  [3:0]  gnt;
  axi_addr_t   awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  axi_resp_t   bresp;
  logic        bvalid;
  logic        bready;
  axi_addr_t   araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  axi_resp_t   rresp;
  logic        rvalid;
  logic        rready;

  vgpr_word_t shadow   [64][NUM_LANES];
  vgpr_word_t ent_data [NUM_ENT][NUM_LANES*QUADS];
  logic       started  [NUM_ENT];
  logic       granted  [NUM_ENT];
  int         active   [NUM_PORTS];  // entry on each port or -1 when idle
  port_sel_t  port_en_mdl;
  int         ptr_mdl;
  int         cyc;
  int         done_cnt;
  int         checks;
  int         errs     [NUM_TESTS+1];

  tb_clock_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(8)) u_clk
  (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  vgpr_wr_top #(.NUM_LANES(NUM_LANES), .NUM_PORTS(NUM_PORTS)) DUT
  (
    .clk_i (clk), .rst_n_i (rst_n),
    .port0_wr_en_i (wr_en[0]), .port0_wr_mask_i (wr_mask[0]),
    .port0_wr_addr_i (wr_addr[0]), .port0_wr_data_i (narrow_data[0]),
    .port0_wr_gnt_o (gnt[0]),
    .port1_wr_en_i (wr_en[1]), .port1_wr_mask_i (wr_mask[1]),
    .port1_wr_addr_i (wr_addr[1]), .port1_wr_data_i (narrow_data[1]),
    .port1_wr_gnt_o (gnt[1]),
    .port2_wr_en_i (wr_en[2]), .port2_wr_mask_i (wr_mask[2]),
    .port2_wr_addr_i (wr_addr[2]), .port2_wr_data_i (narrow_data[2]),
    .port2_wr_gnt_o (gnt[2]),
    .port3_wr_en_i (wr_en[3]), .port3_wr_mask_i (wr_mask[3]),
    .port3_wr_addr_i (wr_addr[3]), .port3_wr_data_i (wide_data),
    .port3_wr_gnt_o (gnt[3]),
    .s_axi_awaddr_i (awaddr), .s_axi_awvalid_i (awvalid), .s_axi_awready_o (awready),
    .s_axi_wdata_i (wdata), .s_axi_wstrb_i (wstrb), .s_axi_wvalid_i (wvalid),
    .s_axi_wready_o (wready), .s_axi_bresp_o (bresp), .s_axi_bvalid_o (bvalid),
    .s_axi_bready_i (bready), .s_axi_araddr_i (araddr), .s_axi_arvalid_i (arvalid),
    .s_axi_arready_o (arready), .s_axi_rdata_o (rdata), .s_axi_rresp_o (rresp),
    .s_axi_rvalid_o (rvalid), .s_axi_rready_i (rready)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~ compare tasks ~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_word(input int t, input vgpr_word_t got, input vgpr_word_t exp,
                            input string what);
    checks++;
    if (got !== exp)
    begin
      errs[t]++;
      $display("Mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input int t, input axi_resp_t got, input axi_resp_t exp,
                            input string what);
    checks++;
    if (got !== exp)
    begin
      errs[t]++;
      $display("Mismatch at %0d ns: %s response got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_sel(input int t, input port_sel_t got, input port_sel_t exp);
    checks++;
    if (got !== exp)
    begin
      errs[t]++;
      $display("Mismatch at %0d ns: grant got %b expected %b", $time, got, exp);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~ shadow model ~~~~~~~~~~~~~~~~~~~~~~~~~~

  // first enabled requester at or after the pointer
  function automatic port_sel_t predict_grant(input port_sel_t req, input port_sel_t en,
                                              input int ptr);
    port_sel_t g;
    int        c;
    g = '0;
    for (int i = NUM_PORTS - 1; i >= 0; i--)
    begin
      c = (ptr + i) % NUM_PORTS;
      if (req[c] && en[c])
        g = port_sel_t'(1 << c);
    end
    return g;
  endfunction

  // narrow ports carry their lane word in quad 0 only
  function automatic vgpr_word_t quad_word(input int e, input int l, input int k);
    if (stim[e].port == NUM_PORTS - 1)
      return ent_data[e][l*QUADS + k];
    return (k == 0) ? ent_data[e][l*QUADS] : '0;
  endfunction

  task automatic apply_entry(input int e);
    int r;
    for (int k = 0; k < QUADS; k++)
    begin
      r = (int'(stim[e].addr) + k) % 64;
      for (int l = 0; l < NUM_LANES; l++)
      begin
        if (stim[e].en[k] && stim[e].mask[l])
          shadow[r][l] = quad_word(e, l, k);
      end
    end
  endtask

  task automatic drive_port(input int p);
    int e;
    e = active[p];
    wr_en[p]   = (e < 0) ? '0 : stim[e].en;
    wr_mask[p] = (e < 0) ? '0 : stim[e].mask;
    wr_addr[p] = (e < 0) ? '0 : stim[e].addr;
    for (int i = 0; i < NUM_LANES * QUADS; i++)
    begin
      if (p == NUM_PORTS - 1)
        wide_data[i] = (e < 0) ? '0 : ent_data[e][i];
      else if (i < NUM_LANES)
        narrow_data[p][i] = (e < 0) ? '0 : ent_data[e][i*QUADS];
    end
  endtask

  // walks the table one cycle at a time and checks the grants mid-cycle
  task automatic run_table();
    port_sel_t req;
    port_sel_t exp;
    int        t;
    while (done_cnt < NUM_ENT)
    begin
      @(posedge clk);
      cyc++;
      #1;
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        if (active[p] >= 0 && granted[active[p]])
          active[p] = -1;
        for (int e = 0; e < NUM_ENT; e++)
        begin
          if (active[p] < 0 && !started[e] && stim[e].port == p && stim[e].start <= cyc)
          begin
            started[e] = 1'b1;
            active[p]  = e;
            for (int i = 0; i < NUM_LANES * QUADS; i++)
              ent_data[e][i] = $urandom() ^ stim[e].seed;
          end
        end
        drive_port(p);
      end
      @(negedge clk);
      req = '0;
      t   = 0;
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        req[p] = (active[p] >= 0);
        if (t == 0 && active[p] >= 0)
          t = stim[active[p]].test;
      end
      exp = predict_grant(req, port_en_mdl, ptr_mdl);
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        if (exp[p])
        begin
          t = stim[active[p]].test;
          apply_entry(active[p]);
          granted[active[p]] = 1'b1;
          done_cnt++;
          ptr_mdl = (p + 1) % NUM_PORTS;
        end
      end
      check_sel((t == 0) ? 4 : t, port_sel_t'(gnt), exp);
    end
    @(posedge clk);
    #1;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      active[p] = -1;
      drive_port(p);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~ AXI4-Lite master ~~~~~~~~~~~~~~~~~~~~~~

  task automatic axi_write(input axi_addr_t addr, input logic [31:0] data,
                           output axi_resp_t resp);
    @(posedge clk);
    #1;
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    @(posedge clk);
    if (addr == REG_PORT_EN)
      port_en_mdl = data[3:0];  // takes effect at this edge
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    resp = bresp;
    @(posedge clk);
    #1 bready = 1'b1;
    @(posedge clk);
    #1 bready = 1'b0;
  endtask

  task automatic axi_read(input axi_addr_t addr, output logic [31:0] data,
                          output axi_resp_t resp);
    @(posedge clk);
    #1;
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    #1 arvalid = 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;
    resp = rresp;
    @(posedge clk);
    #1 rready = 1'b1;
    @(posedge clk);
    #1 rready = 1'b0;
  endtask

  task automatic check_reg(input int t, input vgpr_addr_t r, input logic [1:0] l);
    axi_resp_t   resp;
    logic [31:0] data;
    axi_write(REG_DBG_ADDR, {22'd0, l, 2'd0, r}, resp);
    check_resp(t, resp, RESP_OKAY, "DBG_ADDR write");
    axi_read(REG_DBG_DATA, data, resp);
    check_resp(t, resp, RESP_OKAY, "DBG_DATA read");
    check_word(t, data, shadow[r][l], $sformatf("reg %0d lane %0d", r, l));
  endtask

  task automatic verify_range(input int t, input int base, input int n);
    for (int i = 0; i < n; i++)
    begin
      for (int l = 0; l < NUM_LANES; l++)
        check_reg(t, vgpr_addr_t'((base + i) % 64), 2'(l));
    end
  endtask

  task automatic report_test(input int t, input string name);
    $display("test %0d %s: %s, %0d errors", t, name, (errs[t] == 0) ? "pass" : "fail", errs[t]);
  endtask

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_NS);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    axi_resp_t   resp;
    logic [31:0] data;
    int          total;
    logic        stall_gnt;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      active[p] = -1;
      drive_port(p);
    end
    {awaddr, awvalid, wdata, wstrb, wvalid, bready} = '0;
    {araddr, arvalid, rready} = '0;
    for (int r = 0; r < 64; r++)
      for (int l = 0; l < NUM_LANES; l++)
        shadow[r][l] = '0;
    for (int e = 0; e < NUM_ENT; e++)
    begin
      started[e] = 1'b0;
      granted[e] = 1'b0;
    end
    for (int t = 0; t <= NUM_TESTS; t++)
      errs[t] = 0;
    port_en_mdl = 4'hF;
    stall_gnt   = 1'b0;
    {ptr_mdl, cyc, done_cnt, checks} = '0;
    void'($urandom(32'hebc2));
    wait (rst_n === 1'b1);

    axi_read(REG_PORT_EN, data, resp);
    check_resp(1, resp, RESP_OKAY, "PORT_EN read");
    check_word(1, data, 32'h0000_000F, "PORT_EN");
    axi_read(REG_WR_COUNT, data, resp);
    check_resp(1, resp, RESP_OKAY, "WR_COUNT read");
    check_word(1, data, 32'd0, "WR_COUNT");
    check_reg(1, 6'd0, 2'd0);
    check_reg(1, 6'd17, 2'd1);
    check_reg(1, 6'd62, 2'd2);
    check_reg(1, 6'd63, 2'd3);
    report_test(1, "reset values");

    fork
      run_table();
      begin
        while (cyc < 40) @(posedge clk);
        axi_write(REG_PORT_EN, 32'h0000_000B, resp);
        check_resp(5, resp, RESP_OKAY, "PORT_EN write");
        // the DUT grant for port 2 must stay low for the whole window
        while (cyc < 80)
        begin
          @(negedge clk);
          if (gnt[2])
            stall_gnt = 1'b1;
        end
        if (!started[STALL_ENT] || stall_gnt)
        begin
          errs[5]++;
          $display("port 2 was not held off while its enable bit was clear");
        end
        axi_write(REG_PORT_EN, 32'h0000_000F, resp);
        check_resp(5, resp, RESP_OKAY, "PORT_EN write");
      end
    join

    verify_range(2, 10, 2);
    verify_range(2, 20, 2);
    report_test(2, "narrow masked writes");
    verify_range(3, 30, 4);
    verify_range(3, 40, 4);
    verify_range(3, 62, 4);
    report_test(3, "wide quad writes");
    verify_range(4, 50, 6);
    report_test(4, "round robin order");
    verify_range(5, 5, 2);
    report_test(5, "port enable stall");

    axi_read(REG_WR_COUNT, data, resp);
    check_resp(6, resp, RESP_OKAY, "WR_COUNT read");
    check_word(6, data, vgpr_word_t'(NUM_ENT), "WR_COUNT");
    axi_write(REG_WR_COUNT, 32'h0000_1234, resp);  // any value clears
    check_resp(6, resp, RESP_OKAY, "WR_COUNT write");
    axi_read(REG_WR_COUNT, data, resp);
    check_word(6, data, 32'd0, "WR_COUNT after clear");
    axi_write(REG_DBG_DATA, 32'h0, resp);
    check_resp(6, resp, RESP_SLVERR, "DBG_DATA write");
    axi_write(4'h6, 32'h0, resp);
    check_resp(6, resp, RESP_SLVERR, "unmapped write");
    axi_read(4'h6, data, resp);
    check_resp(6, resp, RESP_SLVERR, "unmapped read");
    check_word(6, data, 32'd0, "unmapped read data");
    report_test(6, "counter and errors");

    total = 0;
    for (int t = 1; t <= NUM_TESTS; t++)
      total += errs[t];
    $display("%0d checks, %0d errors, %0d assertion failures",
             checks, total, DUT.u_checker.fail_cnt);
    if (total == 0 && DUT.u_checker.fail_cnt == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- testbench/vgpr_wr_checker.sv
`timescale 1ns/1ps

module vgpr_wr_checker
  import vgpr_pkg::*;
(
  input logic      clk_i,
  input logic      rst_n_i,
  input port_sel_t req_i,
  input port_sel_t sel_i,
  input logic      bvalid_i,
  input logic      bready_i,
  input logic      rvalid_i,
  input logic      rready_i
);

  int unsigned fail_cnt = 0;  // read by the testbench for its verdict

  a_sel_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(sel_i))
  else
  begin
    $error("grant vector %b is not one-hot", sel_i);
    fail_cnt++;
  end

  // a grant only ever answers a live request
  a_sel_has_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                  (sel_i & ~req_i) == '0)
  else
  begin
    $error("grant %b without request %b", sel_i, req_i);
    fail_cnt++;
  end

  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                  bvalid_i && !bready_i |=> bvalid_i)
  else
  begin
    $error("bvalid dropped before bready");
    fail_cnt++;
  end

  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                  rvalid_i && !rready_i |=> rvalid_i)
  else
  begin
    $error("rvalid dropped before rready");
    fail_cnt++;
  end

endmodule

bind vgpr_wr_top vgpr_wr_checker u_checker
(
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .req_i    (req),
  .sel_i    (sel),
  .bvalid_i (s_axi_bvalid_o),
  .bready_i (s_axi_bready_i),
  .rvalid_i (s_axi_rvalid_o),
  .rready_i (s_axi_rready_i)
);

//--- vgpr_wr.f
hdl/vgpr_pkg.sv
hdl/vgpr_wr_arbiter.sv
hdl/vgpr_wr_port_mux.sv
hdl/vgpr_bank.sv
hdl/vgpr_csr.sv
hdl/vgpr_wr_top.sv
testbench/tb_clock_gen.sv
testbench/vgpr_wr_checker.sv
testbench/tb_vgpr_wr_top.sv
